//--- src/rv_pkg.sv
// RV32I core shared types
package rv_pkg;

    localparam int XLEN  = 32;                            // data width.
    localparam int TAG_W = 4;                             // epoch tag width.

    localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(4);  // pc step.

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        xu_alu, xu_branch, xu_jump, xu_load, xu_store, xu_lui
    } xu_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    typedef enum logic {
        br_beq, br_bne
    } br_op_e;

    // ******************************************************************
    // pipeline packets
    // ******************************************************************

    typedef struct packed {
        logic             valid;    // slot holds an instruction.
        logic [TAG_W-1:0] tag;      // epoch at fetch.
        logic [XLEN-1:0]  npc;      // pc of this instruction.
        logic [XLEN-1:0]  op_a;     // rs1 value.
        logic [XLEN-1:0]  op_b;     // rs2 value, also store data.
        logic [XLEN-1:0]  imm;      // sign extended.
        logic [4:0]       rd;
        xu_e              xu;
        alu_op_e          alu_op;
        br_op_e           br_op;
        logic             use_imm;  // alu b from imm.
    } decode_pkt_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [4:0]       rd;
        xu_e              xu;
        logic [XLEN-1:0]  result;      // alu, link or lui value.
        logic [XLEN-1:0]  target;      // redirect pc.
        logic             jump;        // taken branch or jal.
        logic [XLEN-1:0]  mem_addr;
        logic [XLEN-1:0]  store_data;
    } retire_pkt_t;

    // units that leave a value in rd.
    function automatic logic writes_rd(xu_e xu);
        return xu inside {xu_alu, xu_jump, xu_load, xu_lui};
    endfunction

endpackage

//--- src/fetch.sv
// Fetch stage
`timescale 1ns/1ps
module fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_stall,      // decoder hazard.
    input  logic                     i_jump,       // redirect from retire.
    input  logic [rv_pkg::XLEN-1:0]  i_new_pc,
    output logic [rv_pkg::XLEN-1:0]  o_i_address,
    output logic [rv_pkg::XLEN-1:0]  o_npc,        // pc of the returned word.
    output logic [rv_pkg::TAG_W-1:0] o_tag         // epoch of the returned word.
);

    logic [rv_pkg::XLEN-1:0]  pc;
    logic [rv_pkg::TAG_W-1:0] tag;                 // live epoch.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc    <= RESET_PC;
            tag   <= '0;
            o_npc <= RESET_PC;
            o_tag <= '1;                           // word in flight at reset is stale.
        end else begin
            o_npc <= pc;                           // line up with memory latency.
            o_tag <= tag;
            if (i_jump) begin
                pc  <= i_new_pc;                   // redirect wins over stall.
                tag <= tag + 1'b1;                 // open a new epoch.
            end else if (!i_stall) begin
                pc <= pc + rv_pkg::INSTR_BYTES;
            end
        end
    end

    assign o_i_address = pc;

    // redirect targets come from retire, so alignment spans the pipe.
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_i_address[1:0] == 2'b00);

endmodule

//--- src/decoder.sv
// Decode and issue stage
`timescale 1ns/1ps
module decoder (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic [rv_pkg::XLEN-1:0]  i_instruction,
    input  logic [rv_pkg::XLEN-1:0]  i_npc,
    input  logic [rv_pkg::TAG_W-1:0] i_tag,
    input  logic [rv_pkg::TAG_W-1:0] i_cur_tag,   // retire epoch.
    input  logic [rv_pkg::XLEN-1:0]  i_data_a,
    input  logic [rv_pkg::XLEN-1:0]  i_data_b,
    input  logic                     i_busy_a,
    input  logic                     i_busy_b,
    input  logic                     i_busy_d,
    output logic [4:0]               o_addr_a,
    output logic [4:0]               o_addr_b,
    output logic                     o_lock_en,
    output logic [4:0]               o_lock_addr,
    output logic                     o_stall,
    output rv_pkg::decode_pkt_t      o_pkt
);

    typedef struct packed {
        logic [rv_pkg::XLEN-1:0]  instr;
        logic [rv_pkg::XLEN-1:0]  npc;
        logic [rv_pkg::TAG_W-1:0] tag;
    } fetched_t;

    fetched_t                in_w;
    fetched_t                hold_w;                // word kept over a stall.
    fetched_t                cur_w;
    logic                    hold_v;
    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    alt;
    rv_pkg::alu_op_e         alu_fn;
    rv_pkg::xu_e             xu;
    logic [rv_pkg::XLEN-1:0] imm;
    logic                    known;
    logic                    use_a;
    logic                    use_b;
    logic                    use_imm;
    logic                    wb;
    logic                    fresh;
    logic                    issue;

    assign in_w   = '{instr: i_instruction, npc: i_npc, tag: i_tag};
    assign cur_w  = hold_v ? hold_w : in_w;
    assign opcode = rv_pkg::opcode_e'(cur_w.instr[6:0]);
    assign funct3 = cur_w.instr[14:12];
    assign funct7 = cur_w.instr[31:25];

    // bit 30 picks sub/sra, but addi never means sub.
    assign alt = cur_w.instr[30] && (opcode == rv_pkg::opc_op || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  alu_fn = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  alu_fn = rv_pkg::alu_sll;
            3'b010:  alu_fn = rv_pkg::alu_slt;
            3'b011:  alu_fn = rv_pkg::alu_sltu;
            3'b100:  alu_fn = rv_pkg::alu_xor;
            3'b101:  alu_fn = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  alu_fn = rv_pkg::alu_or;
            default: alu_fn = rv_pkg::alu_and;
        endcase
    end

    // ******************************************************************
    // format decode
    // ******************************************************************

    always_comb begin
        known   = 1'b1;
        use_a   = 1'b1;                                        // rs1 read.
        use_b   = 1'b0;                                        // rs2 read.
        use_imm = 1'b1;
        xu      = rv_pkg::xu_alu;
        imm     = {{20{cur_w.instr[31]}}, cur_w.instr[31:20]}; // I type.
        case (opcode)
            rv_pkg::opc_op: begin
                use_b   = 1'b1;
                use_imm = 1'b0;
                known   = (funct7 == 7'b0000000) ||
                          (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});
            end
            rv_pkg::opc_op_imm: begin
            end
            rv_pkg::opc_lui: begin
                use_a = 1'b0;
                xu    = rv_pkg::xu_lui;
                imm   = {cur_w.instr[31:12], 12'b0};           // U type.
            end
            rv_pkg::opc_branch: begin
                use_b = 1'b1;
                xu    = rv_pkg::xu_branch;
                known = (funct3[2:1] == 2'b00);                // beq, bne only.
                imm   = {{19{cur_w.instr[31]}}, cur_w.instr[31], cur_w.instr[7],
                         cur_w.instr[30:25], cur_w.instr[11:8], 1'b0};
            end
            rv_pkg::opc_jal: begin
                use_a = 1'b0;
                xu    = rv_pkg::xu_jump;
                imm   = {{11{cur_w.instr[31]}}, cur_w.instr[31], cur_w.instr[19:12],
                         cur_w.instr[20], cur_w.instr[30:21], 1'b0};
            end
            rv_pkg::opc_load: begin
                xu    = rv_pkg::xu_load;
                known = (funct3 == 3'b010);                    // lw only.
            end
            rv_pkg::opc_store: begin
                use_b = 1'b1;
                xu    = rv_pkg::xu_store;
                known = (funct3 == 3'b010);                    // sw only.
                imm   = {{20{cur_w.instr[31]}}, cur_w.instr[31:25], cur_w.instr[11:7]};
            end
            default: known = 1'b0;                             // becomes a bubble.
        endcase
    end

    // ******************************************************************
    // hazard and issue
    // ******************************************************************

    assign o_addr_a    = cur_w.instr[19:15];
    assign o_addr_b    = cur_w.instr[24:20];
    assign o_lock_addr = cur_w.instr[11:7];

    assign wb      = rv_pkg::writes_rd(xu);
    assign fresh   = (cur_w.tag == i_cur_tag);                 // drop old epoch.
    assign o_stall = fresh && known &&
                     ((use_a && i_busy_a) || (use_b && i_busy_b) || (wb && i_busy_d));
    assign issue     = fresh && known && !o_stall;
    assign o_lock_en = issue && wb && (o_lock_addr != 5'd0);   // x0 never busy.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hold_v <= 1'b0;
        end else begin
            hold_v <= o_stall;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_stall) begin
            hold_w <= cur_w;                                   // refetch not needed.
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pkt <= '0;
        end else begin
            o_pkt.valid   <= issue;                            // bubble otherwise.
            o_pkt.tag     <= cur_w.tag;
            o_pkt.npc     <= cur_w.npc;
            o_pkt.op_a    <= i_data_a;
            o_pkt.op_b    <= i_data_b;
            o_pkt.imm     <= imm;
            o_pkt.rd      <= o_lock_addr;
            o_pkt.xu      <= xu;
            o_pkt.alu_op  <= alu_fn;
            o_pkt.br_op   <= funct3[0] ? rv_pkg::br_bne : rv_pkg::br_beq;
            o_pkt.use_imm <= use_imm;
        end
    end

    // a fresh lock must show as busy one cycle later.
    a_lock_seen: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_lock_en |=> !(o_lock_en && o_lock_addr == $past(o_lock_addr)));

endmodule

//--- src/execute.sv
// Execute stage
`timescale 1ns/1ps
module execute (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  rv_pkg::decode_pkt_t     i_pkt,
    output rv_pkg::retire_pkt_t     o_pkt,
    output logic                    o_read,          // load request.
    output logic [rv_pkg::XLEN-1:0] o_read_address
);

    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_out;
    logic [rv_pkg::XLEN-1:0] result;
    logic [rv_pkg::XLEN-1:0] mem_addr;
    logic [4:0]              shamt;
    logic                    taken;

    assign op_b  = i_pkt.use_imm ? i_pkt.imm : i_pkt.op_b;
    assign shamt = op_b[4:0];

    // ******************************************************************
    // alu
    // ******************************************************************

    always_comb begin
        case (i_pkt.alu_op)
            rv_pkg::alu_add:  alu_out = i_pkt.op_a + op_b;
            rv_pkg::alu_sub:  alu_out = i_pkt.op_a - op_b;
            rv_pkg::alu_and:  alu_out = i_pkt.op_a & op_b;
            rv_pkg::alu_or:   alu_out = i_pkt.op_a | op_b;
            rv_pkg::alu_xor:  alu_out = i_pkt.op_a ^ op_b;
            rv_pkg::alu_slt:  alu_out = rv_pkg::XLEN'($signed(i_pkt.op_a) < $signed(op_b));
            rv_pkg::alu_sltu: alu_out = rv_pkg::XLEN'(i_pkt.op_a < op_b);
            rv_pkg::alu_sll:  alu_out = i_pkt.op_a << shamt;
            rv_pkg::alu_srl:  alu_out = i_pkt.op_a >> shamt;
            rv_pkg::alu_sra:  alu_out = $signed(i_pkt.op_a) >>> shamt;
            default:          alu_out = '0;
        endcase
    end

    // beq takes on equal, bne on unequal.
    assign taken = (i_pkt.op_a == i_pkt.op_b) ^ (i_pkt.br_op == rv_pkg::br_bne);

    always_comb begin
        case (i_pkt.xu)
            rv_pkg::xu_jump: result = i_pkt.npc + rv_pkg::INSTR_BYTES;  // link.
            rv_pkg::xu_lui:  result = i_pkt.imm;
            default:         result = alu_out;
        endcase
    end

    assign mem_addr = i_pkt.op_a + i_pkt.imm;                         // lw/sw base + offset.

    // data comes back while retire holds the packet.
    assign o_read         = i_pkt.valid && (i_pkt.xu == rv_pkg::xu_load);
    assign o_read_address = mem_addr;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pkt <= '0;
        end else begin
            o_pkt.valid      <= i_pkt.valid;
            o_pkt.tag        <= i_pkt.tag;
            o_pkt.rd         <= i_pkt.rd;
            o_pkt.xu         <= i_pkt.xu;
            o_pkt.result     <= result;
            o_pkt.target     <= i_pkt.npc + i_pkt.imm;                // branch and jal.
            o_pkt.jump       <= (i_pkt.xu == rv_pkg::xu_jump) ||
                                (i_pkt.xu == rv_pkg::xu_branch && taken);
            o_pkt.mem_addr   <= mem_addr;
            o_pkt.store_data <= i_pkt.op_b;                           // rs2 as read.
        end
    end

endmodule

//--- src/retire.sv
// Retire stage
`timescale 1ns/1ps
module retire (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  rv_pkg::retire_pkt_t      i_pkt,
    input  logic [rv_pkg::XLEN-1:0]  i_data_in,       // load data.
    output logic                     o_reg_we,
    output logic                     o_reg_release,
    output logic [4:0]               o_reg_addr,
    output logic [rv_pkg::XLEN-1:0]  o_reg_data,
    output logic                     o_jump,
    output logic [rv_pkg::XLEN-1:0]  o_new_pc,
    output logic [rv_pkg::TAG_W-1:0] o_cur_tag,
    output logic [3:0]               o_write,         // byte strobe.
    output logic [rv_pkg::XLEN-1:0]  o_write_address,
    output logic [rv_pkg::XLEN-1:0]  o_data_out
);

    logic [rv_pkg::TAG_W-1:0] cur_tag;
    logic                     live;                   // not on the wrong path.
    logic                     wb;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cur_tag <= '0;
        end else if (o_jump) begin
            cur_tag <= cur_tag + 1'b1;                // tracks the fetch epoch.
        end
    end

    assign live = i_pkt.valid && (i_pkt.tag == cur_tag);
    assign wb   = rv_pkg::writes_rd(i_pkt.xu);

    // killed packets still free their lock.
    assign o_reg_release = i_pkt.valid && wb;
    assign o_reg_we      = live && wb;
    assign o_reg_addr    = i_pkt.rd;
    assign o_reg_data    = (i_pkt.xu == rv_pkg::xu_load) ? i_data_in : i_pkt.result;

    assign o_jump    = live && i_pkt.jump;
    assign o_new_pc  = i_pkt.target;
    assign o_cur_tag = cur_tag;

    assign o_write         = (live && i_pkt.xu == rv_pkg::xu_store) ? 4'b1111 : 4'b0000;
    assign o_write_address = i_pkt.mem_addr;
    assign o_data_out      = i_pkt.store_data;

    a_jump_from_cf: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_jump |-> i_pkt.xu inside {rv_pkg::xu_branch, rv_pkg::xu_jump});

    a_target_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_jump |-> o_new_pc[1:0] == 2'b00);

endmodule

//--- src/regbank.sv
// Register bank with busy bits
`timescale 1ns/1ps
module regbank (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic [4:0]              i_addr_a,
    input  logic [4:0]              i_addr_b,
    output logic [rv_pkg::XLEN-1:0] o_data_a,
    output logic [rv_pkg::XLEN-1:0] o_data_b,
    input  logic                    i_lock_en,        // issue of a writer.
    input  logic [4:0]              i_lock_addr,
    input  logic                    i_we,
    input  logic                    i_release,
    input  logic [4:0]              i_wr_addr,
    input  logic [rv_pkg::XLEN-1:0] i_wr_data,
    output logic                    o_busy_a,
    output logic                    o_busy_b,
    output logic                    o_busy_d
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];             // x0 not stored.
    logic [31:1]             busy;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (i_we && i_wr_addr != 5'd0) begin
                regs[i_wr_addr] <= i_wr_data;
            end
            for (int i = 1; i < 32; i++) begin
                if (i_lock_en && i_lock_addr == 5'(i)) begin
                    busy[i] <= 1'b1;                  // new lock beats release.
                end else if (i_release && i_wr_addr == 5'(i)) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    assign o_data_a = (i_addr_a == 5'd0) ? '0 : regs[i_addr_a];
    assign o_data_b = (i_addr_b == 5'd0) ? '0 : regs[i_addr_b];
    assign o_busy_a = (i_addr_a != 5'd0) && busy[i_addr_a];
    assign o_busy_b = (i_addr_b != 5'd0) && busy[i_addr_b];
    assign o_busy_d = (i_lock_addr != 5'd0) && busy[i_lock_addr];

endmodule

//--- src/rv_core.sv
// RV32I core top level
`timescale 1ns/1ps
module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic [rv_pkg::XLEN-1:0] i_instruction,    // word for last address.
    output logic [rv_pkg::XLEN-1:0] o_i_address,
    output logic                    o_read,
    output logic [rv_pkg::XLEN-1:0] o_read_address,
    input  logic [rv_pkg::XLEN-1:0] i_data_in,
    output logic [rv_pkg::XLEN-1:0] o_data_out,
    output logic [rv_pkg::XLEN-1:0] o_write_address,
    output logic [3:0]              o_write
);

    logic [rv_pkg::XLEN-1:0]  npc;
    logic [rv_pkg::XLEN-1:0]  new_pc;
    logic [rv_pkg::XLEN-1:0]  data_a;
    logic [rv_pkg::XLEN-1:0]  data_b;
    logic [rv_pkg::XLEN-1:0]  reg_data;
    logic [rv_pkg::TAG_W-1:0] fetch_tag;
    logic [rv_pkg::TAG_W-1:0] cur_tag;
    logic [4:0]               addr_a;
    logic [4:0]               addr_b;
    logic [4:0]               lock_addr;
    logic [4:0]               reg_addr;
    logic                     stall;
    logic                     jump;
    logic                     busy_a;
    logic                     busy_b;
    logic                     busy_d;
    logic                     lock_en;
    logic                     reg_we;
    logic                     reg_release;
    rv_pkg::decode_pkt_t      dec_pkt;
    rv_pkg::retire_pkt_t      ret_pkt;

    // ******************************************************************
    // pipeline stages
    // ******************************************************************

    fetch #(.RESET_PC(RESET_PC)) fetch_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_stall(stall),
        .i_jump(jump), .i_new_pc(new_pc),
        .o_i_address(o_i_address), .o_npc(npc), .o_tag(fetch_tag)
    );

    decoder decoder_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_instruction(i_instruction), .i_npc(npc), .i_tag(fetch_tag), .i_cur_tag(cur_tag),
        .i_data_a(data_a), .i_data_b(data_b),
        .i_busy_a(busy_a), .i_busy_b(busy_b), .i_busy_d(busy_d),
        .o_addr_a(addr_a), .o_addr_b(addr_b),
        .o_lock_en(lock_en), .o_lock_addr(lock_addr),
        .o_stall(stall), .o_pkt(dec_pkt)
    );

    execute execute_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_pkt(dec_pkt), .o_pkt(ret_pkt),
        .o_read(o_read), .o_read_address(o_read_address)
    );

    retire retire_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_pkt(ret_pkt), .i_data_in(i_data_in),
        .o_reg_we(reg_we), .o_reg_release(reg_release),
        .o_reg_addr(reg_addr), .o_reg_data(reg_data),
        .o_jump(jump), .o_new_pc(new_pc), .o_cur_tag(cur_tag),
        .o_write(o_write), .o_write_address(o_write_address), .o_data_out(o_data_out)
    );

    // ******************************************************************
    // register bank
    // ******************************************************************

    regbank regbank_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_addr_a(addr_a), .i_addr_b(addr_b), .o_data_a(data_a), .o_data_b(data_b),
        .i_lock_en(lock_en), .i_lock_addr(lock_addr),
        .i_we(reg_we), .i_release(reg_release), .i_wr_addr(reg_addr), .i_wr_data(reg_data),
        .o_busy_a(busy_a), .o_busy_b(busy_b), .o_busy_d(busy_d)
    );

endmodule

//--- verification/tb_rv_core.sv
// Testbench for the RV32I core
`timescale 1ns/1ps
module tb_rv_core;

    localparam logic [31:0] SEED           = 32'hd446_80ef;
    localparam int          N_RANDOM       = 200;              // random body length.
    localparam int          LOOP_IDX       = N_RANDOM + 7;     // after the register dump.
    localparam logic [31:0] LOOP_PC        = 32'(LOOP_IDX * 4);
    localparam int          TIMEOUT_CYCLES = N_RANDOM * 8 + 200;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } store_t;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic [31:0] instr = '0;
    logic [31:0] i_address;
    logic        rd_en;
    logic [31:0] rd_address;
    logic [31:0] data_in = '0;
    logic [31:0] data_out;
    logic [31:0] wr_address;
    logic [3:0]  wr_strobe;

    logic [31:0] prog [0:255];                                 // instruction memory.
    logic [31:0] dmem [0:63];                                  // data region.
    logic [31:0] dmem_init [0:63];
    logic [31:0] rng;
    store_t      exp_q [$];                                    // stores from the model.
    store_t      want;
    logic [7:0]  fetch_idx = '0;
    logic [5:0]  read_idx = '0;
    logic        read_pend = 1'b0;
    logic        went_past = 1'b0;
    logic        finished = 1'b0;
    int          cycles = 0;
    int          errors = 0;
    int          stores_seen = 0;
    int          n_expected = 0;

    always #4 clk = ~clk;                                      // 8 ns period.

    rv_core #(.RESET_PC(32'h0)) rv_core_inst (
        .i_clk(clk), .i_arst_n(arst_n),
        .i_instruction(instr), .o_i_address(i_address),
        .o_read(rd_en), .o_read_address(rd_address), .i_data_in(data_in),
        .o_data_out(data_out), .o_write_address(wr_address), .o_write(wr_strobe)
    );

    // ******************************************************************
    // random numbers and encoders
    // ******************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [4:0] pick_reg(input logic [2:0] v);
        return 5'(32'(v) % 7 + 1);                             // x1 to x7.
    endfunction

    // op index: add sub sll slt sltu xor srl sra or and.
    function automatic logic [2:0] op_f3(input int op);
        case (op)
            0, 1:    return 3'b000;
            2:       return 3'b001;
            3:       return 3'b010;
            4:       return 3'b011;
            5:       return 3'b100;
            6, 7:    return 3'b101;
            8:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [6:0] op_f7(input int op);
        return (op == 1 || op == 7) ? 7'b0100000 : 7'b0000000;
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_store(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // ******************************************************************
    // program generator and isa model
    // ******************************************************************

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          op;
        int          off;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'(i) << 12;                            // opcode 0, a bubble.
        end
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            dmem_init[i] = rng;
            dmem[i] = rng;
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            rng = xorshift32(rng);
            r = rng;
            rng = xorshift32(rng);
            s = rng;
            rd  = pick_reg(r[6:4]);
            rs1 = pick_reg(r[9:7]);
            rs2 = pick_reg(r[12:10]);
            op  = int'(r[19:13]) % 10;
            off = 1 + int'(r[22:20]);                          // forward words.
            if (i + off > N_RANDOM) begin
                off = N_RANDOM - i;                            // land on the dump at most.
            end
            case (r[3:0])
                4'd4, 4'd5, 4'd6: begin
                    if (op == 1) begin
                        op = 0;                                // no subi.
                    end
                    imm = s[11:0];
                    if (op_f3(op) == 3'b001 || op_f3(op) == 3'b101) begin
                        imm = {op_f7(op), s[4:0]};             // shamt form.
                    end
                    prog[i] = {imm, rs1, op_f3(op), rd, 7'b0010011};
                end
                4'd7:         prog[i] = {s[19:0], rd, 7'b0110111};
                4'd8, 4'd9:   prog[i] = {4'b0, s[5:0], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
                4'd10, 4'd11: prog[i] = enc_store({4'b0, s[11:6], 2'b00}, rs2, 5'd0);
                4'd12, 4'd13: prog[i] = enc_branch(13'(off * 4), rs2, rs1, {2'b00, s[0]});
                4'd14:        prog[i] = enc_jal(21'(off * 4), {2'b00, s[2:0]});
                default:      prog[i] = {op_f7(op), rs2, rs1, op_f3(op), rd, 7'b0110011};
            endcase
        end
        for (int i = 0; i < 7; i++) begin
            prog[N_RANDOM + i] = enc_store(12'(4 * i), 5'(i + 1), 5'd0);  // register dump.
        end
        prog[LOOP_IDX] = enc_jal(21'd0, 5'd0);                 // self loop.
    endtask

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] mem [0:63];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i_imm;
        logic [31:0] addr;
        logic [31:0] nxt;
        logic [4:0]  rd;
        store_t      st;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            mem[k] = dmem_init[k];
        end
        pc = '0;
        steps = 0;
        while (pc != LOOP_PC && steps < 1000) begin
            ins   = prog[pc[9:2]];
            rd    = ins[11:7];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            i_imm = {{20{ins[31]}}, ins[31:20]};
            nxt   = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: x[rd] = ref_alu(ins[14:12], ins[30], a, b);
                7'b0010011: x[rd] = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101,
                                            a, i_imm);
                7'b0110111: x[rd] = {ins[31:12], 12'h000};
                7'b0000011: begin
                    addr  = a + i_imm;
                    x[rd] = mem[addr[7:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[7:2]] = b;
                    st.addr = addr;
                    st.data = b;
                    st.strb = 4'b1111;
                    exp_q.push_back(st);
                end
                7'b1100011: begin
                    if ((a == b) != ins[12]) begin             // beq or bne taken.
                        nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    x[rd] = pc + 32'd4;                        // link.
                    nxt   = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: ;
            endcase
            x[0] = '0;
            pc = nxt;
            steps++;
        end
        assert (pc == LOOP_PC) else begin
            errors++;
            $display("model did not reach the self loop");
        end
    endtask

    // ******************************************************************
    // memories and store checks
    // ******************************************************************

    always @(negedge clk) begin
        instr     <= prog[fetch_idx];                          // word for last address.
        fetch_idx <= i_address[9:2];
        if (read_pend) begin
            data_in <= dmem[read_idx];
        end
        read_pend <= rd_en;
        read_idx  <= rd_address[7:2];
        if (wr_strobe != 4'b0000) begin
            stores_seen++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("unexpected store to %08h after all expected stores", wr_address);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (wr_address == want.addr) else begin
                    errors++;
                    $display("mismatch o_write_address: got %08h, expected %08h",
                             wr_address, want.addr);
                end
                assert (data_out == want.data) else begin
                    errors++;
                    $display("mismatch o_data_out: got %08h, expected %08h",
                             data_out, want.data);
                end
                assert (wr_strobe == want.strb) else begin
                    errors++;
                    $display("mismatch o_write: got %01h, expected %01h", wr_strobe, want.strb);
                end
            end
            dmem[wr_address[7:2]] = data_out;                  // after the read above.
        end
        if (exp_q.size() == 0 && i_address > LOOP_PC) begin
            went_past <= 1'b1;                                 // fetch ran ahead of the loop.
        end
        if (went_past && i_address == LOOP_PC) begin
            finished <= 1'b1;                                  // loop jal retired.
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        rng = SEED;
        build_program();
        run_model();
        n_expected = exp_q.size();
        repeat (4) @(negedge clk);
        assert (i_address == 32'h0) else begin
            errors++;
            $display("mismatch o_i_address: got %08h, expected %08h", i_address, 32'h0);
        end
        assert (wr_strobe == 4'h0) else begin
            errors++;
            $display("mismatch o_write: got %01h, expected %01h", wr_strobe, 4'h0);
        end
        arst_n = 1'b1;
        while (!finished && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (!finished) begin
            errors++;
            $display("timeout: the program did not complete in %0d cycles", TIMEOUT_CYCLES);
        end
        $display("errors %0d, stores seen %0d of %0d", errors, stores_seen, n_expected);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
src/rv_pkg.sv
src/fetch.sv
src/decoder.sv
src/execute.sv
src/retire.sv
src/regbank.sv
src/rv_core.sv
verification/tb_rv_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f sim.f
	./obj_dir/Vtb_rv_core > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Simulation finished: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
